/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// core widths.
`define XLEN 64
`define IMEM_DEPTH 64
`define IMEM_AW 6

// apb address map.
`define APB_AW 12
`define ADDR_AREA_MASK 12'hF00
`define ADDR_IMEM_BASE 12'h000
`define ADDR_CTRL 12'h100
`define ADDR_RETIRED 12'h104
`define ADDR_REG_BASE 12'h200

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [31:0] u32;
    typedef logic [`XLEN-1:0] word_t;

    typedef enum logic [6:0] {
        OPCODE_OP    = 7'h33,
        OPCODE_OPIMM = 7'h13
    } opcode_t;

    typedef enum logic [2:0] {
        NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // funct3 shared by register and immediate forms.
    localparam logic [2:0] FUNC3_ADD  = 3'b000;
    localparam logic [2:0] FUNC3_XOR  = 3'b100;
    localparam logic [2:0] FUNC3_OR   = 3'b110;
    localparam logic [2:0] FUNC3_AND  = 3'b111;
    localparam logic [2:0] FUNC3_ADDI = FUNC3_ADD;
    localparam logic [2:0] FUNC3_XORI = FUNC3_XOR;
    localparam logic [2:0] FUNC3_ORI  = FUNC3_OR;
    localparam logic [2:0] FUNC3_ANDI = FUNC3_AND;

    localparam logic [6:0] FUNC7_BASE = 7'h00;
    localparam logic [6:0] FUNC7_SUB  = 7'h20;

    typedef struct packed {
        alu_op_t aluop;
        logic    reg_write;
        logic    alusrc;
    } control_t;

    typedef struct packed {
        logic              valid;
        logic [`IMEM_AW:0] pc;
        u32                instr;
    } fetch_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        logic       reg_write;
        word_t      result;
    } ex_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [`APB_AW-1:0] paddr;
        u32                pwdata;
    } apb_req_t;

    typedef struct packed {
        u32   prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

endpackage

/* decoder.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module decoder
    import cpu_pkg::*;
(
    input  u32       raw_instr,
    output word_t    imm,
    output control_t ctl
);

    opcode_t    opcode;
    logic [2:0] f3;
    logic [6:0] f7;

    assign opcode = opcode_t'(raw_instr[6:0]);
    assign f3     = raw_instr[14:12];
    assign f7     = raw_instr[31:25];

    always_comb begin
        ctl = '0;
        imm = '0;
        case (opcode)
            OPCODE_OP: begin
                case (f3)
                    FUNC3_ADD: begin
                        if (f7 == FUNC7_SUB) begin
                            ctl.aluop = ALU_SUB;
                        end else if (f7 == FUNC7_BASE) begin
                            ctl.aluop = ALU_ADD;
                        end
                    end
                    FUNC3_XOR: begin
                        if (f7 == FUNC7_BASE) begin
                            ctl.aluop = ALU_XOR;
                        end
                    end
                    FUNC3_OR: begin
                        if (f7 == FUNC7_BASE) begin
                            ctl.aluop = ALU_OR;
                        end
                    end
                    FUNC3_AND: begin
                        if (f7 == FUNC7_BASE) begin
                            ctl.aluop = ALU_AND;
                        end
                    end
                    default: begin
                        ctl.aluop = NOP;
                    end
                endcase
                ctl.reg_write = (ctl.aluop != NOP);
            end

            OPCODE_OPIMM: begin
                case (f3)
                    FUNC3_ADDI: ctl.aluop = ALU_ADD;
                    FUNC3_XORI: ctl.aluop = ALU_XOR;
                    FUNC3_ORI:  ctl.aluop = ALU_OR;
                    FUNC3_ANDI: ctl.aluop = ALU_AND;
                    default:    ctl.aluop = NOP;
                endcase
                // slti, sltiu and shifts fall through as nop.
                if (ctl.aluop != NOP) begin
                    ctl.reg_write = 1'b1;
                    ctl.alusrc    = 1'b1;
                    imm = {{(`XLEN-12){raw_instr[31]}}, raw_instr[31:20]};
                end
            end

            default: begin
                ctl.aluop = NOP;
            end
        endcase
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps

module regfile
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] raddr1,
    input  logic [4:0] raddr2,
    input  logic [4:0] waddr,
    input  logic [4:0] host_raddr,
    input  logic       wen,
    input  word_t      wdata,
    output word_t      rdata1,
    output word_t      rdata2,
    output word_t      host_rdata
);

    word_t regs [32];

    // x0 reads zero whatever sits in slot 0.
    function automatic word_t read_reg(input logic [4:0] addr);
        read_reg = (addr == 5'd0) ? '0 : regs[addr];
    endfunction

    assign rdata1     = read_reg(raddr1);
    assign rdata2     = read_reg(raddr2);
    assign host_rdata = read_reg(host_raddr);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

/* execute.sv */
`timescale 1ns/1ps

module execute
    import cpu_pkg::*;
(
    input  control_t   ctl,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  word_t      rdata1,
    input  word_t      rdata2,
    input  word_t      imm,
    input  ex_t        wb,
    output word_t      result
);

    logic  wb_fwd;
    word_t op_a;
    word_t op_b_reg;
    word_t op_b;

    // ##################################################################
    // forwarding from writeback
    // ##################################################################
    assign wb_fwd   = wb.valid && wb.reg_write && (wb.rd != 5'd0);
    assign op_a     = (wb_fwd && wb.rd == rs1) ? wb.result : rdata1;
    assign op_b_reg = (wb_fwd && wb.rd == rs2) ? wb.result : rdata2;
    assign op_b     = ctl.alusrc ? imm : op_b_reg;

    // ##################################################################
    // alu
    // ##################################################################
    always_comb begin
        case (ctl.aluop)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_AND: result = op_a & op_b;
            default: result = '0;
        endcase
    end

endmodule

/* core.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module core
    import cpu_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    output logic [`IMEM_AW-1:0] imem_addr,
    input  u32                  imem_data,
    input  word_t               imm,
    input  control_t            ctl,
    output u32                  instr,
    input  word_t               result,
    output ex_t                 wb,
    output logic                busy,
    output logic                done,
    output logic [31:0]         retired
);

    logic [`IMEM_AW:0] pc;
    fetch_t            f_q;
    ex_t               wb_q;
    logic              run;
    logic              done_q;
    logic [31:0]       retired_q;
    logic              halt;
    logic              ex_ok;

    assign imem_addr = pc[`IMEM_AW-1:0];

    // a fetch past the last word counts as a zero word.
    assign halt  = f_q.valid && (f_q.pc[`IMEM_AW] || f_q.instr == '0);
    assign ex_ok = f_q.valid && !halt;
    assign instr = ex_ok ? f_q.instr : '0;

    assign wb      = wb_q;
    assign busy    = run;
    assign done    = done_q;
    assign retired = retired_q;

    always_ff @(posedge clk) begin
        if (reset || (start && !run)) begin
            run            <= start && !reset;
            done_q         <= 1'b0;
            pc             <= '0;
            f_q.valid      <= 1'b0;
            wb_q.valid     <= 1'b0;
            wb_q.reg_write <= 1'b0;
            retired_q      <= '0;
        end else begin
            // fetch, squashed once the stop word reaches execute.
            if (run && !halt) begin
                f_q.valid <= 1'b1;
                f_q.pc    <= pc;
                f_q.instr <= imem_data;
                if (!pc[`IMEM_AW]) begin
                    pc <= pc + 1'b1;
                end
            end else begin
                f_q.valid <= 1'b0;
            end
            if (halt) begin
                run    <= 1'b0;
                done_q <= 1'b1;
            end
            wb_q.valid     <= ex_ok;
            wb_q.rd        <= f_q.instr[11:7];
            wb_q.reg_write <= ex_ok && ctl.reg_write;
            wb_q.result    <= result;
            if (wb_q.reg_write) begin
                retired_q <= retired_q + 1'b1;
            end
        end
    end

endmodule

/* apb_host_port.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module apb_host_port
    import cpu_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  apb_req_t            req,
    output apb_rsp_t            rsp,
    output logic                start,
    input  logic                busy,
    input  logic                done,
    input  logic [31:0]         retired,
    input  logic [`IMEM_AW-1:0] imem_addr,
    output u32                  imem_data,
    output logic [4:0]          host_raddr,
    input  word_t               host_rdata
);

    u32   imem [`IMEM_DEPTH];
    logic access;
    logic in_imem;
    logic is_ctrl;
    logic is_retired;
    logic in_regs;
    logic start_q;
    u32   rdata;

    // ##################################################################
    // address decode
    // ##################################################################
    assign access     = req.psel && req.penable;
    assign in_imem    = (req.paddr & `ADDR_AREA_MASK) == `ADDR_IMEM_BASE;
    assign in_regs    = (req.paddr & `ADDR_AREA_MASK) == `ADDR_REG_BASE;
    assign is_ctrl    = req.paddr == `ADDR_CTRL;
    assign is_retired = req.paddr == `ADDR_RETIRED;
    assign host_raddr = req.paddr[7:3];

    // instruction memory, locked while the core runs.
    always_ff @(posedge clk) begin
        if (access && req.pwrite && in_imem && !busy) begin
            imem[req.paddr[`IMEM_AW+1:2]] <= req.pwdata;
        end
    end

    assign imem_data = imem[imem_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q <= 1'b0;
        end else begin
            start_q <= access && req.pwrite && is_ctrl && req.pwdata[0] && !busy && !start_q;
        end
    end

    assign start = start_q;

    // ##################################################################
    // read mux
    // ##################################################################
    always_comb begin
        rdata = '0;
        if (is_ctrl) begin
            rdata = {30'b0, done, busy};
        end else if (is_retired) begin
            rdata = retired;
        end else if (in_regs) begin
            rdata = req.paddr[2] ? host_rdata[`XLEN-1:32] : host_rdata[31:0];
        end
    end

    assign rsp.prdata  = rdata;
    assign rsp.pready  = access;
    assign rsp.pslverr = access && req.pwrite && in_imem && busy;

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic                start;
    logic                busy;
    logic                done;
    logic [31:0]         retired;
    logic [`IMEM_AW-1:0] imem_addr;
    u32                  imem_data;
    logic [4:0]          host_raddr;
    word_t               host_rdata;
    u32                  instr;
    word_t               imm;
    control_t            ctl;
    word_t               result;
    ex_t                 wb;
    word_t               rdata1;
    word_t               rdata2;

    apb_host_port apb_host_port_inst (
        .clk(clk), .reset(reset), .req(apb_req), .rsp(apb_rsp),
        .start(start), .busy(busy), .done(done), .retired(retired),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .host_raddr(host_raddr), .host_rdata(host_rdata)
    );

    core core_inst (
        .clk(clk), .reset(reset), .start(start),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .imm(imm), .ctl(ctl), .instr(instr), .result(result), .wb(wb),
        .busy(busy), .done(done), .retired(retired)
    );

    decoder decoder_inst (.raw_instr(instr), .imm(imm), .ctl(ctl));

    // writeback reg_write is already qualified by valid.
    execute execute_inst (
        .ctl(ctl), .rs1(instr[19:15]), .rs2(instr[24:20]),
        .rdata1(rdata1), .rdata2(rdata2), .imm(imm), .wb(wb), .result(result)
    );

    regfile regfile_inst (
        .clk(clk), .reset(reset),
        .raddr1(instr[19:15]), .raddr2(instr[24:20]),
        .waddr(wb.rd), .host_raddr(host_raddr),
        .wen(wb.reg_write), .wdata(wb.result),
        .rdata1(rdata1), .rdata2(rdata2), .host_rdata(host_rdata)
    );

endmodule

/* tb_cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int TEST_COUNT = 6;

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    integer      seed = 58378;
    int          err_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    u32          prog[$];
    logic [63:0] model_regs[32];
    int          model_retired;

    cpu_top cpu_top_inst (.clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_COUNT * 2000 * CLK_PERIOD);
        $display("timeout: the run went past %0d clock cycles", TEST_COUNT * 2000);
        $display("Verification failed");
        $finish;
    end

    // ##################################################################
    // apb transfers, setup then access
    // ##################################################################
    task automatic apb_write(input logic [`APB_AW-1:0] addr, input u32 data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        err = apb_rsp.pslverr;
        check_value("pready", {63'b0, apb_rsp.pready}, 64'h1);
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [`APB_AW-1:0] addr, output u32 data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        check_value("pready", {63'b0, apb_rsp.pready}, 64'h1);
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            err_count++;
        end
    endtask

    // ##################################################################
    // encoders and reference model
    // ##################################################################
    function automatic u32 enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3,
                                 input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic u32 enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // every supported encoding retires, x0 targets included.
    task automatic model_exec(input u32 ins);
        logic [63:0] b;
        logic        ok;
        logic        sub;
        b   = model_regs[ins[24:20]];
        ok  = 1'b0;
        sub = 1'b0;
        if (ins[6:0] == 7'h33) begin
            ok  = (ins[31:25] == 7'h00 && ins[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111})
                  || (ins[31:25] == 7'h20 && ins[14:12] == 3'b000);
            sub = ins[30];
        end else if (ins[6:0] == 7'h13) begin
            ok = ins[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111};
            b  = {{52{ins[31]}}, ins[31:20]};
        end
        if (ok) begin
            model_retired++;
            if (ins[11:7] != 5'd0) begin
                model_regs[ins[11:7]] = alu_ref(ins[14:12], sub, model_regs[ins[19:15]], b);
            end
        end
    endtask

    task automatic model_program();
        model_retired = 0;
        foreach (prog[i]) begin
            model_exec(prog[i]);
        end
    endtask

    // ##################################################################
    // program control
    // ##################################################################
    task automatic load_program();
        logic err;
        foreach (prog[i]) begin
            apb_write(12'(`ADDR_IMEM_BASE + 4 * i), prog[i], err);
            check_value("pslverr", {63'b0, err}, 64'h0);
        end
        apb_write(12'(`ADDR_IMEM_BASE + 4 * prog.size()), 32'h0, err);
        check_value("pslverr", {63'b0, err}, 64'h0);
    endtask

    task automatic start_program();
        logic err;
        apb_write(`ADDR_CTRL, 32'h1, err);
    endtask

    task automatic wait_done();
        u32 status;
        int polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < 200) begin
            apb_read(`ADDR_CTRL, status);
            polls++;
        end
        if (!status[1]) begin
            $display("core never reported done after %0d status reads", polls);
            err_count++;
        end else begin
            check_value("status", {32'b0, status}, 64'h2);
        end
    endtask

    task automatic run_program();
        start_program();
        wait_done();
    endtask

    task automatic check_retired();
        u32 count;
        apb_read(`ADDR_RETIRED, count);
        check_value("retired", {32'b0, count}, 64'(model_retired));
    endtask

    task automatic check_regs();
        u32 lo;
        u32 hi;
        for (int i = 0; i < 32; i++) begin
            apb_read(12'(`ADDR_REG_BASE + 8 * i), lo);
            apb_read(12'(`ADDR_REG_BASE + 8 * i + 4), hi);
            check_value($sformatf("x%0d", i), {hi, lo}, model_regs[i]);
        end
    endtask

    task automatic load_run_check();
        load_program();
        model_program();
        run_program();
        check_retired();
        check_regs();
    endtask

    task automatic report_test(input string name, input int e0);
        test_count++;
        if (err_count == e0) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, err_count - e0);
        end
    endtask

    // ##################################################################
    // tests
    // ##################################################################
    task automatic test_reset_state();
        int e0;
        u32 data;
        e0 = err_count;
        apb_read(`ADDR_CTRL, data);
        check_value("status", {32'b0, data}, 64'h0);
        model_retired = 0;
        check_retired();
        check_regs();
        report_test("reset state", e0);
    endtask

    task automatic test_imm_ops();
        int          e0;
        logic [11:0] imm;
        logic [2:0]  f3;
        e0 = err_count;
        prog.delete();
        for (int k = 0; k < 12; k++) begin
            imm = 12'($random(seed));
            // odd steps carry a negative immediate.
            if (k % 2 == 1) begin
                imm[11] = 1'b1;
            end
            case (k % 4)
                0:       f3 = 3'b000;
                1:       f3 = 3'b100;
                2:       f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            prog.push_back(enc_i(imm, 5'(k), f3, 5'(k + 1)));
        end
        load_run_check();
        report_test("immediate forms", e0);
    endtask

    task automatic test_reg_forwarding();
        int e0;
        e0 = err_count;
        prog.delete();
        for (int k = 13; k < 17; k++) begin
            prog.push_back(enc_i(12'($random(seed)), 5'd0, 3'b000, 5'(k)));
        end
        prog.push_back(enc_r(7'h00, 5'd14, 5'd13, 3'b000, 5'd17));
        prog.push_back(enc_r(7'h20, 5'd15, 5'd17, 3'b000, 5'd18));
        prog.push_back(enc_r(7'h00, 5'd17, 5'd18, 3'b100, 5'd19));
        prog.push_back(enc_r(7'h00, 5'd18, 5'd19, 3'b110, 5'd20));
        prog.push_back(enc_r(7'h00, 5'd16, 5'd20, 3'b111, 5'd21));
        prog.push_back(enc_r(7'h00, 5'd21, 5'd21, 3'b000, 5'd22));
        prog.push_back(enc_r(7'h20, 5'd22, 5'd13, 3'b000, 5'd22));
        load_run_check();
        report_test("register forms with forwarding", e0);
    endtask

    task automatic test_x0_and_illegal();
        int e0;
        e0 = err_count;
        prog.delete();
        prog.push_back(enc_i(12'h5a5, 5'd0, 3'b000, 5'd0));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        prog.push_back(enc_i(12'h005, 5'd1, 3'b010, 5'd3));
        prog.push_back(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b100, 5'd5));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd6));
        prog.push_back({12'h010, 5'd1, 3'b011, 5'd7, 7'h03});
        prog.push_back(enc_i(12'h123, 5'd1, 3'b100, 5'd8));
        prog.push_back(enc_r(7'h00, 5'd0, 5'd8, 3'b110, 5'd0));
        // x0 result in writeback must not reach this read.
        prog.push_back(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
        load_run_check();
        report_test("x0 writes and unsupported codes", e0);
    endtask

    task automatic test_busy_write();
        int   e0;
        logic err;
        e0 = err_count;
        prog.delete();
        for (int k = 24; k < 28; k++) begin
            prog.push_back(enc_i(12'($random(seed)), 5'd0, 3'b000, 5'(k)));
        end
        prog.push_back(enc_r(7'h00, 5'd25, 5'd24, 3'b000, 5'd28));
        prog.push_back(enc_r(7'h20, 5'd26, 5'd28, 3'b000, 5'd29));
        prog.push_back(enc_r(7'h00, 5'd27, 5'd29, 3'b100, 5'd30));
        prog.push_back(enc_r(7'h00, 5'd24, 5'd30, 3'b111, 5'd31));
        prog.push_back(enc_r(7'h00, 5'd28, 5'd31, 3'b110, 5'd31));
        load_program();
        model_program();
        start_program();
        // target the last word, which is fetched well after this write.
        apb_write(12'(`ADDR_IMEM_BASE + 4 * (prog.size() - 1)),
                  enc_i(12'h7ff, 5'd0, 3'b000, 5'd24), err);
        check_value("pslverr", {63'b0, err}, 64'h1);
        wait_done();
        check_retired();
        check_regs();
        report_test("instruction write while busy", e0);
    endtask

    task automatic test_rerun();
        int e0;
        u32 status;
        e0 = err_count;
        model_program();
        start_program();
        // the rerun is still in flight at the first poll.
        apb_read(`ADDR_CTRL, status);
        check_value("status", {32'b0, status}, 64'h1);
        wait_done();
        check_retired();
        check_regs();
        report_test("second start", e0);
    endtask

    initial begin
        reset   = 1'b1;
        apb_req = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_imm_ops();
        test_reg_forwarding();
        test_x0_and_illegal();
        test_busy_write();
        test_rerun();
        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
cpu_pkg.sv
decoder.sv
regfile.sv
execute.sv
core.sv
apb_host_port.sv
cpu_top.sv
tb_cpu_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cpu_top -f build.f -o sim_cpu_top

./obj_dir/sim_cpu_top > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
